//--- src.f
+incdir+logic
logic/hps_io_pkg.sv
logic/uio_word_if.sv
logic/uio_cmd_decode.sv
logic/uio_input_regs.sv
logic/ps2_key_tracker.sv
logic/uio_readback.sv
logic/hps_io_lite.sv
bench/tb_hps_io.sv

//--- Bender.yml
package:
  name: hps_io_lite

sources:
  - include_dirs:
      - logic
    files:
      - logic/hps_io_pkg.sv
      - logic/uio_word_if.sv
      - logic/uio_cmd_decode.sv
      - logic/uio_input_regs.sv
      - logic/ps2_key_tracker.sv
      - logic/uio_readback.sv
      - logic/hps_io_lite.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_hps_io.sv

//--- bench/tb_hps_io.sv
/* host i/o channel testbench */

`default_nettype none

`include "hps_io_defs.svh"

module tb_hps_io import hps_io_pkg::*; ();

	// about 20 transactions of at most 11 words, 4 cycles each, stay well under this
	localparam int TIMEOUT_CYCLES = 4000;

	logic                      clk_sys;
	logic                      rst_n;
	logic                      io_enable;
	logic                      io_strobe;
	logic [`HPS_WORD_W-1:0]    io_din;
	logic [`HPS_WORD_W-1:0]    io_dout;
	logic [1:0]                buttons;
	logic                      forced_scandoubler;
	logic                      direct_video;
	logic [31:0]               joystick_0;
	logic [31:0]               joystick_1;
	stick_word_u               joystick_l_analog_0;
	stick_word_u               joystick_l_analog_1;
	logic [7:0]                paddle_0;
	logic [7:0]                paddle_1;
	logic [8:0]                spinner_0;
	logic [8:0]                spinner_1;
	logic [`HPS_STATUS_W-1:0]  status;
	logic [`HPS_STATUS_W-1:0]  status_in;
	logic                      status_set;
	logic [`HPS_WORD_W-1:0]    status_menumask;
	ps2_key_t                  ps2_key;

	integer                    seed;
	int                        cycles = 0;
	ps2_key_t                  key_exp;
	// data words of the next transaction and the io_dout seen for each word
	logic [`HPS_WORD_W-1:0]    tx_words[$];
	logic [`HPS_WORD_W-1:0]    rx_words[$];

	hps_io_lite i_dut (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_stop($sformatf("Timeout: the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic fail_stop(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_word(input logic [`HPS_WORD_W-1:0] got, exp, input string msg);
		if (got !== exp)
			fail_stop($sformatf("Error at time %0t: %s, got %h, expected %h",
				$time, msg, got, exp));
	endtask

	task automatic check_joy(input logic [31:0] got, exp, input string msg);
		if (got !== exp)
			fail_stop($sformatf("Error at time %0t: %s, got %h, expected %h",
				$time, msg, got, exp));
	endtask

	task automatic check_stick(input stick_word_u got, exp, input string msg);
		if (got !== exp)
			fail_stop($sformatf("Error at time %0t: %s, got %h, expected %h",
				$time, msg, got, exp));
	endtask

	task automatic check_status(input logic [`HPS_STATUS_W-1:0] got, exp, input string msg);
		if (got !== exp)
			fail_stop($sformatf("Error at time %0t: %s, got %h, expected %h",
				$time, msg, got, exp));
	endtask

	task automatic check_key(input ps2_key_t got, exp, input string msg);
		if (got !== exp)
			fail_stop($sformatf("Error at time %0t: %s, got %h, expected %h",
				$time, msg, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// host side of the channel
	//////////////////////////////////////////////////////////////////////

	// io_dout is registered two cycles after the strobe
	task automatic read_word();
		repeat (2) @(posedge clk_sys);
		#1;
		rx_words.push_back(io_dout);
	endtask

	task automatic send_word(input logic [`HPS_WORD_W-1:0] w);
		@(posedge clk_sys);
		#1;
		io_din    = w;
		io_strobe = 1'b1;
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
		read_word();
	endtask

	task automatic host_txn(input logic [`HPS_WORD_W-1:0] cmd);
		rx_words.delete();
		@(posedge clk_sys);
		#1;
		io_enable = 1'b1;
		send_word(cmd);
		foreach (tx_words[i])
			send_word(tx_words[i]);
		@(posedge clk_sys);
		#1;
		io_enable = 1'b0;
		// done, then key update and io_dout clear
		repeat (3) @(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_config_joy();
		logic [15:0] lo;
		logic [15:0] hi;
		check_word(io_dout, '0, "io_dout after reset");
		check_word({12'b0, direct_video, forced_scandoubler, buttons}, '0, "cfg after reset");
		check_joy(joystick_0, '0, "joystick 0 after reset");
		check_joy(joystick_1, '0, "joystick 1 after reset");
		check_stick(joystick_l_analog_0, '0, "analog 0 after reset");
		check_stick(joystick_l_analog_1, '0, "analog 1 after reset");
		check_word({paddle_1, paddle_0}, '0, "paddles after reset");
		check_word({7'b0, spinner_0}, '0, "spinner 0 after reset");
		check_word({7'b0, spinner_1}, '0, "spinner 1 after reset");
		check_status(status, '0, "status after reset");
		check_key(ps2_key, '0, "ps2 key after reset");
		// bits 1:0, 4 and 10
		tx_words = {16'h0413};
		host_txn(CMD_CFG);
		check_word({12'b0, direct_video, forced_scandoubler, buttons}, 16'h000F, "cfg all set");
		tx_words = {16'h0010};
		host_txn(CMD_CFG);
		check_word({12'b0, direct_video, forced_scandoubler, buttons}, 16'h0004, "cfg bit 4");
		lo = $random(seed);
		hi = $random(seed);
		tx_words = {lo, hi};
		host_txn(CMD_JOY0);
		check_joy(joystick_0, {hi, lo}, "joystick 0");
		lo = $random(seed);
		hi = $random(seed);
		tx_words = {lo, hi};
		host_txn(CMD_JOY1);
		check_joy(joystick_1, {hi, lo}, "joystick 1");
	endtask

	task automatic test_stick();
		logic [15:0] r;
		stick_word_u exp_a;
		logic [7:0]  exp_pad;
		logic [8:0]  exp_spin;
		r = $random(seed);
		tx_words = {16'h0001, r};
		host_txn(CMD_STICK);
		exp_a.analog.y = r[15:8];
		exp_a.analog.x = r[7:0];
		check_stick(joystick_l_analog_1, exp_a, "analog stick 1");
		check_stick(joystick_l_analog_0, '0, "analog stick 0 untouched");
		// stick nibble 15 selects paddle/spinner, the upper nibble picks which
		r = $random(seed);
		tx_words = {16'h000F, r};
		host_txn(CMD_STICK);
		exp_pad = r[7:0];
		check_word({8'h00, paddle_0}, {8'h00, exp_pad}, "paddle 0");
		exp_spin = '0;
		repeat (2) begin
			r = $random(seed);
			tx_words = {16'h009F, r};
			host_txn(CMD_STICK);
			exp_spin = {~exp_spin[8], r[7:0]};
			check_word({7'b0, spinner_1}, {7'b0, exp_spin}, "spinner 1");
		end
		// stick 7 does not exist
		r = $random(seed);
		tx_words = {16'h0007, r};
		host_txn(CMD_STICK);
		check_stick(joystick_l_analog_0, '0, "analog 0 after index 07h");
		check_stick(joystick_l_analog_1, exp_a, "analog 1 after index 07h");
		check_word({paddle_1, paddle_0}, {8'h00, exp_pad}, "paddles after index 07h");
		check_word({7'b0, spinner_0}, '0, "spinner 0 after index 07h");
		check_word({7'b0, spinner_1}, {7'b0, exp_spin}, "spinner 1 after index 07h");
	endtask

	task automatic test_status();
		logic [`HPS_STATUS_W-1:0] exp;
		logic [15:0]              r;
		exp = '0;
		tx_words.delete();
		for (int i = 0; i < 10; i++) begin
			r = $random(seed);
			tx_words.push_back(r);
			if (i < `HPS_STATUS_WORDS)
				exp[i * `HPS_WORD_W +: `HPS_WORD_W] = r;
		end
		host_txn(CMD_STATUS);
		check_status(status, exp, "status write");
	endtask

	task automatic test_readback();
		logic [`HPS_STATUS_W-1:0] last;
		logic [15:0]              mask;
		last = '0;
		for (int i = 0; i < 3; i++) begin
			repeat (2) @(posedge clk_sys);
			#1;
			last = {$random(seed), $random(seed), $random(seed), $random(seed)};
			status_in  = last;
			status_set = 1'b1;
			repeat (2) @(posedge clk_sys);
			#1;
			status_set = 1'b0;
		end
		tx_words.delete();
		repeat (`HPS_STATUS_WORDS) tx_words.push_back('0);
		host_txn(CMD_STATUS_REQ);
		check_word(rx_words[0], {8'h00, 4'hA, 4'd3}, "status request header");
		for (int i = 0; i < `HPS_STATUS_WORDS; i++)
			check_word(rx_words[i + 1], last[i * `HPS_WORD_W +: `HPS_WORD_W],
				$sformatf("status request word %0d", i + 1));
		check_word(io_dout, '0, "io_dout after status request");
		mask = $random(seed);
		status_menumask = mask;
		tx_words = {16'h0000};
		host_txn(CMD_MENUMASK);
		check_word(rx_words[0], '0, "menu mask command word");
		check_word(rx_words[1], mask, "menu mask");
		check_word(io_dout, '0, "io_dout after menu mask");
	endtask

	// one accepted key event flips the toggle bit
	task automatic key_check(input logic pressed, extended, input logic [7:0] code,
		input string msg);
		host_txn(CMD_KBD);
		key_exp.toggle   = ~key_exp.toggle;
		key_exp.pressed  = pressed;
		key_exp.extended = extended;
		key_exp.code     = code;
		check_key(ps2_key, key_exp, msg);
	endtask

	task automatic test_keyboard();
		tx_words = {16'h001C};
		key_check(1'b1, 1'b0, 8'h1C, "plain press");
		tx_words = {16'h00F0, 16'h001C};
		key_check(1'b0, 1'b0, 8'h1C, "plain release");
		tx_words = {16'h00E0, 16'h0075};
		key_check(1'b1, 1'b1, 8'h75, "extended press");
		tx_words = {16'h00E0, 16'h00F0, 16'h0075};
		key_check(1'b0, 1'b1, 8'h75, "extended release");
		tx_words = {16'h00E0, 16'h0012, 16'h00E0, 16'h007C};
		key_check(1'b1, 1'b1, 8'h7C, "print screen press");
		tx_words = {16'h00E0, 16'h00F0, 16'h007C, 16'h00E0, 16'h00F0, 16'h0012};
		key_check(1'b0, 1'b1, 8'h7C, "print screen release");
		tx_words = {16'h00F0, 16'h0014, 16'h00F0, 16'h0077};
		key_check(1'b1, 1'b1, 8'h77, "pause press");
		// high byte FFh drops the whole event
		tx_words = {16'hFF00, 16'h001C};
		host_txn(CMD_KBD);
		check_key(ps2_key, key_exp, "skipped key event");
	endtask

	initial begin
		seed            = 26;
		clk_sys         = 1'b0;
		rst_n           = 1'b0;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		key_exp         = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		test_config_joy();
		test_stick();
		test_status();
		test_readback();
		test_keyboard();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/hps_io_lite.sv
/* host i/o channel, top level */

`default_nettype none

`include "hps_io_defs.svh"

module hps_io_lite import hps_io_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  wire                     io_enable,
	input  wire                     io_strobe,
	input  wire [`HPS_WORD_W-1:0]   io_din,
	output logic [`HPS_WORD_W-1:0]  io_dout,
	output logic [1:0]              buttons,
	output logic                    forced_scandoubler,
	output logic                    direct_video,
	output logic [31:0]             joystick_0,
	output logic [31:0]             joystick_1,
	output stick_word_u             joystick_l_analog_0,
	output stick_word_u             joystick_l_analog_1,
	output logic [7:0]              paddle_0,
	output logic [7:0]              paddle_1,
	output logic [8:0]              spinner_0,
	output logic [8:0]              spinner_1,
	output logic [`HPS_STATUS_W-1:0] status,
	input  wire [`HPS_STATUS_W-1:0] status_in,
	input  wire                     status_set,
	input  wire [`HPS_WORD_W-1:0]   status_menumask,
	output ps2_key_t                ps2_key
);

	logic [`HPS_NUM_PLAYERS-1:0][31:0] joystick;
	stick_word_u [`HPS_NUM_PLAYERS-1:0] stick_analog;
	logic [`HPS_NUM_PLAYERS-1:0][7:0]  paddle;
	logic [`HPS_NUM_PLAYERS-1:0][8:0]  spinner;

	uio_word_if word_bus ();

	//////////////////////////////////////////////////////////////////////
	// decode, then three consumers of the same word
	//////////////////////////////////////////////////////////////////////

	uio_cmd_decode i_decode (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.io_enable (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (word_bus.src)
	);

	uio_input_regs i_input_regs (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.word               (word_bus.dst),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick           (joystick),
		.stick_analog       (stick_analog),
		.paddle             (paddle),
		.spinner            (spinner),
		.status             (status)
	);

	ps2_key_tracker i_ps2_key (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.word    (word_bus.dst),
		.ps2_key (ps2_key)
	);

	uio_readback i_readback (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.word            (word_bus.dst),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.io_dout         (io_dout)
	);

	// per-player ports
	assign joystick_0          = joystick[0];
	assign joystick_1          = joystick[1];
	assign joystick_l_analog_0 = stick_analog[0];
	assign joystick_l_analog_1 = stick_analog[1];
	assign paddle_0            = paddle[0];
	assign paddle_1            = paddle[1];
	assign spinner_0           = spinner[0];
	assign spinner_1           = spinner[1];

endmodule

`default_nettype wire

//--- logic/uio_readback.sv
/* host read-back */

`default_nettype none

`include "hps_io_defs.svh"

module uio_readback import hps_io_pkg::*; (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	uio_word_if.dst                 word,
	input  wire [`HPS_STATUS_W-1:0] status_in,
	input  wire                     status_set,
	input  wire [`HPS_WORD_W-1:0]   status_menumask,
	output logic [`HPS_WORD_W-1:0]  io_dout
);

	logic                     set_q;
	logic                     set_rise;
	logic [`HPS_CNT_W-1:0]    chg_cnt;
	logic [`HPS_STATUS_W-1:0] status_req;

	assign set_rise = status_set & ~set_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			set_q   <= 1'b0;
			chg_cnt <= '0;
			io_dout <= '0;
		end else begin
			set_q <= status_set;
			if (set_rise)
				chg_cnt <= chg_cnt + 1'b1;
			if (word.done) begin
				io_dout <= '0;
			end else if (word.valid) begin
				io_dout <= '0;
				case (word.cmd)
					CMD_STATUS_REQ: begin
						if (word.first)
							io_dout <= {{(`HPS_WORD_W - 8){1'b0}}, 4'hA, chg_cnt};
						else if (word.idx <= `HPS_STATUS_WORDS)
							io_dout <= status_req[(word.idx - 1) * `HPS_WORD_W +: `HPS_WORD_W];
					end
					CMD_MENUMASK: begin
						if (word.idx == 1)
							io_dout <= status_menumask;
					end
					default: ;
				endcase
			end
		end
	end

	// snapshot of the core status on each rising edge of status_set
	always_ff @(posedge clk_sys) begin
		if (set_rise)
			status_req <= status_in;
	end

endmodule

`default_nettype wire

//--- logic/ps2_key_tracker.sv
/* keyboard key event */

`default_nettype none

`include "hps_io_defs.svh"

module ps2_key_tracker import hps_io_pkg::*; (
	input  wire     clk_sys,
	input  wire     rst_n,
	uio_word_if.dst word,
	output ps2_key_t ps2_key
);

	logic [31:0] raw;
	logic        skip;
	ps2_key_t    key_next;

	always_comb begin
		key_next.toggle   = ~ps2_key.toggle;
		key_next.pressed  = (raw[15:8] != 8'hF0);
		// E0 prefix sits one byte further back on a release
		key_next.extended = key_next.pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);
		key_next.code     = raw[7:0];
		case (raw)
			32'hE012E07C: {key_next.pressed, key_next.extended, key_next.code} = 10'h37C;
			32'h7CE0F012: {key_next.pressed, key_next.extended, key_next.code} = 10'h17C;
			32'hF014F077: {key_next.pressed, key_next.extended, key_next.code} = 10'h377;
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			raw     <= '0;
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (word.valid && word.cmd == CMD_KBD) begin
				if (word.first)
					raw <= '0;
				else if (&word.data[15:8])
					skip <= 1'b1;
				else if (!skip)
					raw <= {raw[23:0], word.data[7:0]};
			end
			if (word.done) begin
				skip <= 1'b0;
				if (word.cmd == CMD_KBD && !skip)
					ps2_key <= key_next;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/uio_input_regs.sv
/* core input registers */

`default_nettype none

`include "hps_io_defs.svh"

module uio_input_regs import hps_io_pkg::*; (
	input  wire                                          clk_sys,
	input  wire                                          rst_n,
	uio_word_if.dst                                      word,
	output logic [1:0]                                   buttons,
	output logic                                         forced_scandoubler,
	output logic                                         direct_video,
	output logic [`HPS_NUM_PLAYERS-1:0][31:0]            joystick,
	output stick_word_u [`HPS_NUM_PLAYERS-1:0]           stick_analog,
	output logic [`HPS_NUM_PLAYERS-1:0][7:0]             paddle,
	output logic [`HPS_NUM_PLAYERS-1:0][8:0]             spinner,
	output logic [`HPS_STATUS_W-1:0]                     status
);

	stick_sel_t  sel;
	stick_word_u din_u;
	logic        joy_sel;

	assign din_u   = word.data;
	assign joy_sel = (word.cmd == CMD_JOY1);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
			direct_video       <= 1'b0;
			joystick           <= '0;
			stick_analog       <= '0;
			paddle             <= '0;
			spinner            <= '0;
			status             <= '0;
			sel                <= '0;
		end else if (word.valid && !word.first) begin
			case (word.cmd)
				CMD_CFG: begin
					buttons            <= word.data[1:0];
					forced_scandoubler <= word.data[4];
					direct_video       <= word.data[10];
				end

				// low half first, then high half
				CMD_JOY0, CMD_JOY1: begin
					if (word.idx == 1)
						joystick[joy_sel][15:0] <= word.data;
					else if (word.idx == 2)
						joystick[joy_sel][31:16] <= word.data;
				end

				CMD_STICK: begin
					if (word.idx == 1) begin
						sel <= stick_sel_t'(word.data[7:0]);
					end else if (word.idx == 2) begin
						if (sel.stick < `HPS_NUM_PLAYERS) begin
							stick_analog[sel.stick].analog <= din_u.analog;
						end else if (sel.stick == 4'hF) begin
							if (sel.pdsp < `HPS_NUM_PLAYERS)
								paddle[sel.pdsp] <= din_u.pad.value;
							// spinner bit 8 flags a fresh update
							else if (sel.pdsp >= 8 && sel.pdsp < 8 + `HPS_NUM_PLAYERS)
								spinner[sel.pdsp - 4'd8] <=
									{~spinner[sel.pdsp - 4'd8][8], din_u.pad.value};
						end
					end
				end

				// 16-bit slices, lowest first
				CMD_STATUS: begin
					if (word.idx <= `HPS_STATUS_WORDS)
						status[(word.idx - 1) * `HPS_WORD_W +: `HPS_WORD_W] <= word.data;
				end

				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/uio_cmd_decode.sv
/* host word decode */

`default_nettype none

`include "hps_io_defs.svh"

module uio_cmd_decode (
	input  wire                   clk_sys,
	input  wire                   rst_n,
	input  wire                   io_enable,
	input  wire                   io_strobe,
	input  wire [`HPS_WORD_W-1:0] io_din,
	uio_word_if.src               word
);

	logic [`HPS_CNT_W-1:0] cnt;
	logic                  enable_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt        <= '0;
			enable_q   <= 1'b0;
			word.valid <= 1'b0;
			word.first <= 1'b0;
			word.cmd   <= '0;
			word.idx   <= '0;
			word.done  <= 1'b0;
		end else begin
			enable_q   <= io_enable;
			word.valid <= 1'b0;
			// falling edge of the enable closes the transaction
			word.done  <= enable_q & ~io_enable;
			if (!io_enable) begin
				cnt <= '0;
			end else if (io_strobe) begin
				word.valid <= 1'b1;
				word.first <= (cnt == '0);
				word.idx   <= cnt;
				if (cnt == '0)
					word.cmd <= io_din;
				// saturate, long transfers keep the last index
				if (~&cnt)
					cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_enable && io_strobe)
			word.data <= io_din;
	end

endmodule

`default_nettype wire

//--- logic/uio_word_if.sv
/* decoded host word */

`default_nettype none

`include "hps_io_defs.svh"

interface uio_word_if;

	logic                   valid;
	logic                   first;
	logic [`HPS_WORD_W-1:0] cmd;
	// 0 is the command word itself
	logic [`HPS_CNT_W-1:0]  idx;
	logic [`HPS_WORD_W-1:0] data;
	// end of transaction, cmd still holds
	logic                   done;

	modport src (output valid, first, cmd, idx, data, done);
	modport dst (input valid, first, cmd, idx, data, done);

endinterface

`default_nettype wire

//--- logic/hps_io_pkg.sv
/* host i/o channel types */

`default_nettype none

`include "hps_io_defs.svh"

package hps_io_pkg;

	// command codes still served by the channel
	typedef enum logic [`HPS_WORD_W-1:0] {
		CMD_CFG        = 'h01,
		CMD_JOY0       = 'h02,
		CMD_JOY1       = 'h03,
		CMD_KBD        = 'h05,
		CMD_STICK      = 'h1A,
		CMD_STATUS     = 'h1E,
		CMD_STATUS_REQ = 'h29,
		CMD_MENUMASK   = 'h2E
	} uio_cmd_e;

	// analog stick, -127..+127 per axis
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} stick_analog_t;

	// paddle or spinner, value in the low byte
	typedef struct packed {
		logic [7:0] unused;
		logic [7:0] value;
	} stick_pad_t;

	typedef union packed {
		stick_analog_t analog;
		stick_pad_t    pad;
	} stick_word_u;

	// index byte of the stick command, stick 15 selects paddle/spinner
	typedef struct packed {
		logic [3:0] pdsp;
		logic [3:0] stick;
	} stick_sel_t;

	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

endpackage

`default_nettype wire

//--- logic/hps_io_defs.svh
/* host i/o channel parameters */

`ifndef HPS_IO_DEFS_SVH
`define HPS_IO_DEFS_SVH

// host word, one per strobe
`define HPS_WORD_W 16

// joysticks, analog sticks, paddles and spinners
`define HPS_NUM_PLAYERS 2

// core status vector and its length in host words
`define HPS_STATUS_W 128
`define HPS_STATUS_WORDS 8

// saturating word counter, stops at 15
`define HPS_CNT_W 4

`endif
